/* project.f */
verilog/cpu_pkg.sv
verilog/register_bank.sv
verilog/alu.sv
verilog/axil_master.sv
verilog/unit_control.sv
verilog/datapath.sv
verilog/cpu_top.sv
test/tb_cpu.sv

/* run.sh */
#!/usr/bin/env bash
# Build and run the tb_cpu simulation with Verilator.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -j 0 --top-module tb_cpu -Mdir obj_dir -f project.f
status=$?
if [ $status -ne 0 ]; then
	echo "Verilator build failed"
	exit $status
fi

./obj_dir/Vtb_cpu
status=$?
if [ $status -ne 0 ]; then
	echo "Simulation failed"
	exit $status
fi

exit 0

/* test/tb_cpu.sv */
`default_nettype none

module tb_cpu;
	import cpu_pkg::*;

	localparam int K_ALU = 0;
	localparam int K_CONST = 1;
	localparam int K_MEM = 2;
	localparam int K_JAL = 3;
	localparam int K_JR = 4;
	localparam int NUM_ROWS = 20;
	localparam int TIMEOUT = 4000;
	localparam word_t DATA_BASE = 32'h0000_0100;
	localparam word_t OUT_BASE = 32'h0000_0180;
	localparam logic [4:0] OP_LD = 5'b00000;
	localparam logic [4:0] OP_ST = 5'b10000; // op bit 4 selects store

	typedef struct {
		int kind;
		logic [4:0] op;
		word_t a;
		word_t b;
		logic [15:0] imm;
	} row_t;

	logic CLK = 1'b0;
	logic rst_n = 1'b0;
	axil_req_t axi_req;
	axil_rsp_t axi_rsp;
	logic halted;

	// memory model state
	logic awready = 1'b0;
	logic wready = 1'b0;
	logic bvalid = 1'b0;
	logic arready = 1'b0;
	logic rvalid = 1'b0;
	word_t rdata = '0;
	logic aw_got;
	logic w_got;
	logic r_busy;
	word_t aw_addr;
	word_t w_data;
	word_t r_addr;
	int aw_cnt;
	int w_cnt;
	int b_cnt;
	int ar_cnt;
	int r_cnt;
	logic [31:0] lfsr_state = 32'h0000_c87a;
	logic use_delay = 1'b0;
	word_t mem [256];
	word_t store_addr [$];
	word_t store_data [$];
	word_t reads [$]; // every AR address, fetches and loads
	word_t exp_addr [$];
	word_t exp_data [$];
	int store_base;
	int read_base;
	row_t rows [NUM_ROWS];

	always #20 CLK = ~CLK;

	cpu_top i_cpu_top (
		.CLK(CLK),
		.rst_n(rst_n),
		.axi_req(axi_req),
		.axi_rsp(axi_rsp),
		.halted(halted)
	);

	always_comb begin
		axi_rsp = '0;
		axi_rsp.awready = awready;
		axi_rsp.wready = wready;
		axi_rsp.bvalid = bvalid;
		axi_rsp.arready = arready;
		axi_rsp.rvalid = rvalid;
		axi_rsp.rdata = rdata;
	end

	function automatic logic lfsr_bit();
		logic fb;
		fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
		lfsr_state = {lfsr_state[30:0], fb};
		return fb;
	endfunction

	function automatic int draw_delay();
		int d;
		d = 0;
		if (use_delay) begin
			if (lfsr_bit())
				d = d + 2;
			if (lfsr_bit())
				d = d + 1;
		end
		return d;
	endfunction

	always @(posedge CLK) begin
		if (!rst_n) begin
			awready <= 1'b0;
			wready <= 1'b0;
			bvalid <= 1'b0;
			arready <= 1'b0;
			rvalid <= 1'b0;
			aw_got <= 1'b0;
			w_got <= 1'b0;
			r_busy <= 1'b0;
			aw_cnt <= draw_delay();
			w_cnt <= draw_delay();
			b_cnt <= draw_delay();
			ar_cnt <= draw_delay();
		end else begin
			if (arready) begin // handshake at this edge
				arready <= 1'b0;
				r_addr <= axi_req.araddr;
				reads.push_back(axi_req.araddr);
				r_busy <= 1'b1;
				r_cnt <= draw_delay();
				ar_cnt <= draw_delay();
			end else if (axi_req.arvalid && !r_busy) begin
				if (ar_cnt == 0)
					arready <= 1'b1;
				else
					ar_cnt <= ar_cnt - 1;
			end
			if (rvalid) begin
				if (axi_req.rready) begin
					rvalid <= 1'b0;
					r_busy <= 1'b0;
				end
			end else if (r_busy) begin
				if (r_cnt == 0) begin
					rvalid <= 1'b1;
					rdata <= mem[r_addr[9:2]];
				end else begin
					r_cnt <= r_cnt - 1;
				end
			end
			if (awready) begin
				awready <= 1'b0;
				aw_got <= 1'b1;
				aw_addr <= axi_req.awaddr;
				aw_cnt <= draw_delay();
			end else if (axi_req.awvalid && !aw_got) begin
				if (aw_cnt == 0)
					awready <= 1'b1;
				else
					aw_cnt <= aw_cnt - 1;
			end
			if (wready) begin
				wready <= 1'b0;
				w_got <= 1'b1;
				w_data <= axi_req.wdata;
				w_cnt <= draw_delay();
			end else if (axi_req.wvalid && !w_got) begin
				if (w_cnt == 0)
					wready <= 1'b1;
				else
					w_cnt <= w_cnt - 1;
			end
			if (bvalid) begin
				if (axi_req.bready) begin
					bvalid <= 1'b0;
					aw_got <= 1'b0;
					w_got <= 1'b0;
					b_cnt <= draw_delay();
				end
			end else if (aw_got && w_got) begin
				if (b_cnt == 0) begin
					bvalid <= 1'b1;
					store_addr.push_back(aw_addr);
					store_data.push_back(w_data);
				end else begin
					b_cnt <= b_cnt - 1;
				end
			end
		end
	end

	task automatic check_word(input word_t got, input word_t exp, input string msg);
		if (got !== exp) begin
			$display("Fail %0t: %s got %h expected %h", $time, msg, got, exp);
			$display("Test failed");
			$fatal(1, "data mismatch");
		end
	endtask

	task automatic check_addr(input word_t got, input word_t exp, input string msg);
		if (got !== exp) begin
			$display("Fail %0t: %s address %h expected %h", $time, msg, got, exp);
			$display("Test failed");
			$fatal(1, "address mismatch");
		end
	endtask

	function automatic word_t sext16(input logic [15:0] v);
		return {{16{v[15]}}, v};
	endfunction

	function automatic word_t fill_word(input int idx);
		word_t addr;
		addr = word_t'(idx) << 2;
		return (addr * 32'h9e37_79b1) ^ 32'h5a5a_c3c3;
	endfunction

	function automatic logic [4:0] op_for_tf(input tf_t t);
		return {t[0], t[1], t[2], 2'b00}; // op bits 2,3,4 carry the code
	endfunction

	function automatic instr_t mk_imm(input logic [2:0] itype, input logic [4:0] op,
			input reg_idx_t rd, input reg_idx_t ra, input word_t imm);
		instr_t w;
		w.i.itype = itype;
		w.i.op = op;
		w.i.rd = rd;
		w.i.ra = ra;
		w.i.imm = imm[15:0];
		return w;
	endfunction

	function automatic instr_t mk_reg(input logic [2:0] itype, input logic [4:0] op,
			input reg_idx_t rd, input reg_idx_t ra, input reg_idx_t rb);
		instr_t w;
		w.r.itype = itype;
		w.r.op = op;
		w.r.rd = rd;
		w.r.ra = ra;
		w.r.rb = rb;
		w.r.unused = '0;
		return w;
	endfunction

	// result and flags by op class, starting from the given flags
	task automatic ref_alu(input logic [4:0] op, input word_t a, input word_t b,
			input flags_t f_in, output word_t r, output flags_t f);
		logic c;
		logic o;
		longint sum;
		c = 1'b0;
		o = 1'b0;
		case (op)
			OP_ADD: begin
				r = a + b;
				c = (r < a);
				sum = longint'($signed(a)) + longint'($signed(b)); // exact signed sum
				o = (sum > 64'sd2147483647) || (sum < -64'sd2147483648);
			end
			OP_SUB: begin
				r = a - b;
				c = (a < b);
				sum = longint'($signed(a)) - longint'($signed(b));
				o = (sum > 64'sd2147483647) || (sum < -64'sd2147483648);
			end
			OP_INC: begin
				r = a + 32'd1;
				c = (a == 32'hffff_ffff);
				o = (a == 32'h7fff_ffff);
			end
			OP_DEC: begin
				r = a - 32'd1;
				c = (a == 32'd0);
				o = (a == 32'h8000_0000);
			end
			OP_SHL: begin
				r = a << 1;
				c = a[31];
			end
			OP_SHR: begin
				r = a >> 1;
				c = a[0];
			end
			OP_AND: r = a & b;
			OP_OR: r = a | b;
			OP_PASS: r = b;
			OP_XOR: r = a ^ b;
			OP_NOT: r = ~a;
			OP_ONES: r = 32'hffff_ffff;
			default: r = '0;
		endcase
		f = f_in;
		if (op == OP_ZEROS) begin
			f.z = (r == '0);
		end else if (op != OP_ONES) begin
			f.s = r[31];
			f.z = (r == '0);
			if (op[4:3] == 2'b00 || op[4:3] == 2'b01)
				f.c = c;
			if (op[4:3] == 2'b00)
				f.o = o;
		end
	endtask

	task automatic put(input word_t addr, input word_t w);
		mem[addr[9:2]] = w;
	endtask

	task automatic build_program(input row_t r);
		tf_t conds [4];
		logic flag_bits [4];
		word_t res;
		word_t b;
		flags_t f;
		conds[0] = TF_ZERO;
		conds[1] = TF_NEG;
		conds[2] = TF_CARRY;
		conds[3] = TF_OVF;
		case (r.kind)
			K_ALU: begin
				put(DATA_BASE, r.a);
				put(DATA_BASE + 32'd4, r.b);
				put(32'd0, mk_imm(TYPE_MEM, OP_LD, 4'd1, 4'd0, DATA_BASE));
				put(32'd4, mk_imm(TYPE_MEM, OP_LD, 4'd2, 4'd0, DATA_BASE + 32'd4));
				put(32'd8, mk_reg(TYPE_ALU, r.op, 4'd3, 4'd1, 4'd2));
				put(32'd12, mk_imm(TYPE_MEM, OP_ST, 4'd3, 4'd0, OUT_BASE));
				ref_alu(r.op, r.a, r.b, '0, res, f);
				exp_addr.push_back(OUT_BASE);
				exp_data.push_back(res);
				flag_bits[0] = f.z;
				flag_bits[1] = f.s;
				flag_bits[2] = f.c;
				flag_bits[3] = f.o;
				for (int k = 0; k < 4; k++) begin // one marker per flag
					b = 32'd16 + word_t'(20 * k);
					put(b, mk_imm(TYPE_BRANCH, op_for_tf(conds[k]), 4'd0, 4'd0, b + 32'd12));
					put(b + 32'd4, mk_imm(TYPE_CONST, OP_PASS, 4'd4, 4'd0, 32'd0));
					put(b + 32'd8, mk_imm(TYPE_BRANCH, op_for_tf(TF_ALWAYS), 4'd0, 4'd0,
						b + 32'd16));
					put(b + 32'd12, mk_imm(TYPE_CONST, OP_PASS, 4'd4, 4'd0, 32'd1));
					put(b + 32'd16, mk_imm(TYPE_MEM, OP_ST, 4'd4, 4'd0,
						OUT_BASE + 32'd4 + word_t'(4 * k)));
					exp_addr.push_back(OUT_BASE + 32'd4 + word_t'(4 * k));
					exp_data.push_back({31'd0, flag_bits[k]});
				end
				put(32'd96, mk_reg(TYPE_HALT, 5'd0, 4'd0, 4'd0, 4'd0));
			end
			K_CONST: begin
				put(DATA_BASE, r.a);
				put(32'd0, mk_imm(TYPE_MEM, OP_LD, 4'd1, 4'd0, DATA_BASE));
				put(32'd4, mk_imm(TYPE_CONST, r.op, 4'd3, 4'd1, sext16(r.imm)));
				put(32'd8, mk_imm(TYPE_MEM, OP_ST, 4'd3, 4'd0, OUT_BASE));
				put(32'd12, mk_reg(TYPE_HALT, 5'd0, 4'd0, 4'd0, 4'd0));
				ref_alu(r.op, r.a, sext16(r.imm), '0, res, f);
				exp_addr.push_back(OUT_BASE);
				exp_data.push_back(res);
			end
			K_MEM: begin
				put(DATA_BASE + sext16(r.imm), r.a);
				put(32'd0, mk_imm(TYPE_CONST, OP_PASS, 4'd5, 4'd0, DATA_BASE));
				put(32'd4, mk_imm(TYPE_MEM, OP_LD, 4'd1, 4'd5, sext16(r.imm)));
				put(32'd8, mk_imm(TYPE_MEM, OP_ST, 4'd1, 4'd0, OUT_BASE));
				put(32'd12, mk_reg(TYPE_HALT, 5'd0, 4'd0, 4'd0, 4'd0));
				exp_addr.push_back(OUT_BASE);
				exp_data.push_back(r.a);
			end
			K_JAL: begin
				put(32'd0, mk_imm(TYPE_JUMP, op_for_tf(TF_LINK), 4'd6, 4'd0, sext16(r.imm)));
				put(32'd4, mk_reg(TYPE_HALT, 5'd0, 4'd0, 4'd0, 4'd0)); // fall-through stops
				put(sext16(r.imm), mk_imm(TYPE_MEM, OP_ST, 4'd6, 4'd0, OUT_BASE));
				put(sext16(r.imm) + 32'd4, mk_reg(TYPE_HALT, 5'd0, 4'd0, 4'd0, 4'd0));
				exp_addr.push_back(OUT_BASE);
				exp_data.push_back(32'd4);
			end
			default: begin // jr to 0x60
				put(32'd0, mk_imm(TYPE_CONST, OP_PASS, 4'd7, 4'd0, 32'h60));
				put(32'd4, mk_imm(TYPE_JUMP, op_for_tf(TF_ALWAYS), 4'd0, 4'd7, 32'd0));
				put(32'd8, mk_reg(TYPE_HALT, 5'd0, 4'd0, 4'd0, 4'd0));
				put(32'h60, mk_imm(TYPE_CONST, OP_PASS, 4'd4, 4'd0, sext16(r.imm)));
				put(32'h64, mk_imm(TYPE_MEM, OP_ST, 4'd4, 4'd0, OUT_BASE));
				put(32'h68, mk_reg(TYPE_HALT, 5'd0, 4'd0, 4'd0, 4'd0));
				exp_addr.push_back(OUT_BASE);
				exp_data.push_back(sext16(r.imm));
			end
		endcase
	endtask

	task automatic read_after(input word_t addr, output word_t next);
		logic found;
		found = 1'b0;
		next = '0;
		for (int i = read_base; i < reads.size() - 1; i++) begin
			if (!found && reads[i] == addr) begin
				next = reads[i + 1];
				found = 1'b1;
			end
		end
		if (!found) begin
			$display("No read from %h followed by another read", addr);
			$display("Test failed");
			$fatal(1, "missing read");
		end
	endtask

	task automatic run_row(input row_t r, input int idx);
		int waited;
		word_t next;
		@(posedge CLK);
		rst_n <= 1'b0;
		for (int i = 0; i < 256; i++)
			mem[i] = fill_word(i);
		exp_addr.delete();
		exp_data.delete();
		build_program(r);
		store_base = store_addr.size();
		read_base = reads.size();
		repeat (10) @(posedge CLK);
		rst_n <= 1'b1;
		waited = 0;
		while (store_addr.size() - store_base < exp_addr.size()) begin
			@(negedge CLK);
			waited++;
			if (halted) begin // halt only after the last store
				$display("Halted before all stores were seen in row %0d", idx);
				$display("Test failed");
				$fatal(1, "early halt");
			end
			if (waited > TIMEOUT) begin
				$display("Timed out waiting for stores in row %0d", idx);
				$display("Test failed");
				$fatal(1, "store timeout");
			end
		end
		waited = 0;
		while (!halted) begin
			@(negedge CLK);
			waited++;
			if (waited > TIMEOUT) begin
				$display("Timed out waiting for halted in row %0d", idx);
				$display("Test failed");
				$fatal(1, "halt timeout");
			end
		end
		check_word(word_t'(store_addr.size() - store_base), word_t'(exp_addr.size()),
			$sformatf("row %0d store count", idx));
		for (int k = 0; k < exp_addr.size(); k++) begin
			check_addr(store_addr[store_base + k], exp_addr[k],
				$sformatf("row %0d store %0d", idx, k));
			check_word(store_data[store_base + k], exp_data[k],
				$sformatf("row %0d store %0d", idx, k));
		end
		if (r.kind == K_MEM) begin
			read_after(32'd4, next); // load follows fetch of the ld
			check_addr(next, DATA_BASE + sext16(r.imm), $sformatf("row %0d load", idx));
		end
		if (r.kind == K_JR) begin
			read_after(32'd4, next);
			check_addr(next, 32'h60, $sformatf("row %0d fetch after jr", idx));
		end
	endtask

	initial begin
		rows[0] = '{K_ALU, OP_ADD, 32'h7fff_ffff, 32'h0000_0001, 16'h0};
		rows[1] = '{K_ALU, OP_ADD, 32'hffff_ffff, 32'h0000_0001, 16'h0};
		rows[2] = '{K_ALU, OP_SUB, 32'h0000_0005, 32'h0000_0007, 16'h0};
		rows[3] = '{K_ALU, OP_SUB, 32'h8000_0000, 32'h0000_0001, 16'h0};
		rows[4] = '{K_ALU, OP_INC, 32'hffff_ffff, 32'h0, 16'h0};
		rows[5] = '{K_ALU, OP_DEC, 32'h0000_0000, 32'h0, 16'h0};
		rows[6] = '{K_ALU, OP_SHL, 32'h8000_0001, 32'h0, 16'h0};
		rows[7] = '{K_ALU, OP_SHR, 32'h0000_0003, 32'h0, 16'h0};
		rows[8] = '{K_ALU, OP_AND, 32'hf0f0_1234, 32'hff00_ff00, 16'h0};
		rows[9] = '{K_ALU, OP_OR, 32'h8000_0000, 32'h0000_0001, 16'h0};
		rows[10] = '{K_ALU, OP_XOR, 32'h0000_a5a5, 32'h0000_a5a5, 16'h0};
		rows[11] = '{K_ALU, OP_NOT, 32'h0000_0000, 32'h0, 16'h0};
		rows[12] = '{K_ALU, OP_ZEROS, 32'h0000_1234, 32'h0, 16'h0};
		rows[13] = '{K_ALU, OP_ONES, 32'h0000_0001, 32'h0, 16'h0};
		rows[14] = '{K_CONST, OP_PASS, 32'h0, 32'h0, 16'hfffb};
		rows[15] = '{K_CONST, OP_ADD, 32'h0000_000a, 32'h0, 16'hfffd};
		rows[16] = '{K_MEM, OP_LD, 32'h1234_5678, 32'h0, 16'h0010};
		rows[17] = '{K_MEM, OP_LD, 32'hcafe_0042, 32'h0, 16'h003c};
		rows[18] = '{K_JAL, OP_PASS, 32'h0, 32'h0, 16'h0040};
		rows[19] = '{K_JR, OP_PASS, 32'h0, 32'h0, 16'h8001};
		for (int pass = 0; pass < 2; pass++) begin // second pass with random delays
			use_delay = (pass == 1);
			for (int i = 0; i < NUM_ROWS; i++)
				run_row(rows[i], i);
		end
		$display("Test completed successfully");
		$finish;
	end

endmodule

`default_nettype wire

/* verilog/alu.sv */
`default_nettype none

module alu (
	input wire logic CLK,
	input wire logic rst_n,
	input wire logic [4:0] op,
	input cpu_pkg::word_t a,
	input cpu_pkg::word_t b,
	input wire logic [2:0] w_rf,
	input cpu_pkg::tf_t tf,
	output cpu_pkg::word_t result,
	output logic taken
);
	import cpu_pkg::*;

	flags_t flags;
	flags_t nf;
	flags_t nf_q; // flags of the last execute cycle

	always_comb begin
		logic [32:0] ext;
		ext = '0;
		nf = '0;
		case (op)
			OP_ADD: ext = {1'b0, a} + {1'b0, b};
			OP_SUB: ext = {1'b0, a} - {1'b0, b}; // bit 32 is borrow
			OP_INC: ext = {1'b0, a} + 33'd1;
			OP_DEC: ext = {1'b0, a} - 33'd1;
			OP_SHL: ext = {a[31], a[30:0], 1'b0};
			OP_SHR: ext = {a[0], 1'b0, a[31:1]};
			OP_AND: ext = {1'b0, a & b};
			OP_OR: ext = {1'b0, a | b};
			OP_PASS: ext = {1'b0, b};
			OP_XOR: ext = {1'b0, a ^ b};
			OP_NOT: ext = {1'b0, ~a};
			OP_ONES: ext = {1'b0, 32'hffff_ffff};
			default: ext = '0;
		endcase
		result = ext[31:0];
		nf.c = ext[32]; // carry, borrow or shifted-out bit
		nf.s = result[31];
		nf.z = (result == '0);
		case (op)
			OP_ADD: nf.o = (a[31] == b[31]) && (result[31] != a[31]);
			OP_SUB: nf.o = (a[31] != b[31]) && (result[31] != a[31]);
			OP_INC: nf.o = !a[31] && result[31];
			OP_DEC: nf.o = a[31] && !result[31];
			default: nf.o = 1'b0;
		endcase
	end

	always_ff @(posedge CLK)
		nf_q <= nf;

	always_ff @(posedge CLK) begin
		if (!rst_n) begin
			flags <= '0;
		end else begin
			case (w_rf)
				FLG_Z: flags.z <= nf_q.z;
				FLG_SZ: {flags.s, flags.z} <= {nf_q.s, nf_q.z};
				FLG_SCZ: {flags.s, flags.c, flags.z} <= {nf_q.s, nf_q.c, nf_q.z};
				FLG_OSCZ: flags <= nf_q;
				default: ;
			endcase
		end
	end

	always_comb begin
		case (tf)
			TF_ALWAYS, TF_LINK: taken = 1'b1;
			TF_ZERO: taken = flags.z;
			TF_NZERO: taken = !flags.z;
			TF_NEG: taken = flags.s;
			TF_CARRY: taken = flags.c;
			TF_OVF: taken = flags.o;
			default: taken = 1'b0;
		endcase
	end

endmodule

`default_nettype wire

/* verilog/axil_master.sv */
`default_nettype none

module axil_master (
	input wire logic CLK,
	input wire logic rst_n,
	input cpu_pkg::mem_req_t req,
	output cpu_pkg::mem_rsp_t rsp,
	output cpu_pkg::axil_req_t axi_req,
	input cpu_pkg::axil_rsp_t axi_rsp
);
	import cpu_pkg::*;

	logic awvalid;
	logic wvalid;
	logic bready;
	logic arvalid;
	logic rready;
	logic busy;
	logic r_done;
	logic b_done;
	word_t addr_q;
	word_t wdata_q;

	// a transaction is open until its response is taken
	assign busy = rready || bready;
	assign r_done = rready && axi_rsp.rvalid;
	assign b_done = bready && axi_rsp.bvalid;

	always_ff @(posedge CLK) begin
		if (!rst_n) begin
			awvalid <= 1'b0;
			wvalid <= 1'b0;
			bready <= 1'b0;
			arvalid <= 1'b0;
			rready <= 1'b0;
		end else begin
			if (!busy && req.valid) begin
				if (req.write) begin
					awvalid <= 1'b1;
					wvalid <= 1'b1;
					bready <= 1'b1;
				end else begin
					arvalid <= 1'b1;
					rready <= 1'b1;
				end
			end
			if (awvalid && axi_rsp.awready)
				awvalid <= 1'b0;
			if (wvalid && axi_rsp.wready)
				wvalid <= 1'b0;
			if (arvalid && axi_rsp.arready)
				arvalid <= 1'b0;
			if (r_done)
				rready <= 1'b0;
			if (b_done)
				bready <= 1'b0;
		end
	end

	// payload held stable for the whole transaction
	always_ff @(posedge CLK) begin
		if (!busy && req.valid) begin
			addr_q <= req.addr;
			wdata_q <= req.wdata;
		end
	end

	always_comb begin
		axi_req.awvalid = awvalid;
		axi_req.awaddr = addr_q;
		axi_req.wvalid = wvalid;
		axi_req.wdata = wdata_q;
		axi_req.bready = bready;
		axi_req.arvalid = arvalid;
		axi_req.araddr = addr_q;
		axi_req.rready = rready;
	end

	assign rsp.done = r_done || b_done; // single-cycle pulse
	assign rsp.rdata = axi_rsp.rdata;

endmodule

`default_nettype wire

/* verilog/cpu_pkg.sv */
`default_nettype none

package cpu_pkg;

	typedef logic [31:0] word_t;
	typedef logic [3:0] reg_idx_t;
	typedef logic [2:0] tf_t;

	typedef struct packed {
		logic [2:0] itype;
		logic [4:0] op;
		reg_idx_t rd;
		reg_idx_t ra;
		reg_idx_t rb;
		logic [11:0] unused;
	} instr_reg_t;

	typedef struct packed {
		logic [2:0] itype;
		logic [4:0] op;
		reg_idx_t rd;
		reg_idx_t ra;
		logic signed [15:0] imm;
	} instr_imm_t;

	// same word, register or immediate layout
	typedef union packed {
		instr_reg_t r;
		instr_imm_t i;
	} instr_t;

	localparam logic [2:0] TYPE_BRANCH = 3'b000;
	localparam logic [2:0] TYPE_ALU = 3'b001;
	localparam logic [2:0] TYPE_CONST = 3'b010;
	localparam logic [2:0] TYPE_MEM = 3'b100;
	localparam logic [2:0] TYPE_JUMP = 3'b110;
	localparam logic [2:0] TYPE_HALT = 3'b111;

	localparam logic [4:0] OP_ADD = 5'b00000;
	localparam logic [4:0] OP_SUB = 5'b00001;
	localparam logic [4:0] OP_INC = 5'b00010;
	localparam logic [4:0] OP_DEC = 5'b00011;
	localparam logic [4:0] OP_SHL = 5'b01000;
	localparam logic [4:0] OP_SHR = 5'b01001;
	localparam logic [4:0] OP_ZEROS = 5'b10000;
	localparam logic [4:0] OP_AND = 5'b10001;
	localparam logic [4:0] OP_OR = 5'b10010;
	localparam logic [4:0] OP_PASS = 5'b10011; // passes operand b
	localparam logic [4:0] OP_XOR = 5'b10100;
	localparam logic [4:0] OP_NOT = 5'b10101;
	localparam logic [4:0] OP_ONES = 5'b11111;

	localparam logic [2:0] FLG_NONE = 3'b000;
	localparam logic [2:0] FLG_Z = 3'b001;
	localparam logic [2:0] FLG_SZ = 3'b010;
	localparam logic [2:0] FLG_SCZ = 3'b011;
	localparam logic [2:0] FLG_OSCZ = 3'b100;

	localparam tf_t TF_ALWAYS = 3'b000;
	localparam tf_t TF_ZERO = 3'b001;
	localparam tf_t TF_NZERO = 3'b010;
	localparam tf_t TF_LINK = 3'b011; // always taken, writes link
	localparam tf_t TF_NEG = 3'b100;
	localparam tf_t TF_CARRY = 3'b101;
	localparam tf_t TF_OVF = 3'b110;
	localparam tf_t TF_NEVER = 3'b111;

	localparam logic [1:0] WB_LINK = 2'b00;
	localparam logic [1:0] WB_MEM = 2'b01;
	localparam logic [1:0] WB_ALU = 2'b10;

	typedef struct packed {
		logic [4:0] alu_op;
		tf_t tf;
		logic sel_imm;
		logic w_pc;
		logic w_ir;
		logic w_rb;
		logic [2:0] w_rf;
		logic [1:0] wb_sel;
		logic w_addr;
	} ctrl_t;

	typedef struct packed {
		logic valid;
		logic write;
		word_t addr;
		word_t wdata;
	} mem_req_t;

	typedef struct packed {
		logic done;
		word_t rdata;
	} mem_rsp_t;

	typedef struct packed {
		logic awvalid;
		word_t awaddr;
		logic wvalid;
		word_t wdata;
		logic bready;
		logic arvalid;
		word_t araddr;
		logic rready;
	} axil_req_t;

	typedef struct packed {
		logic awready;
		logic wready;
		logic bvalid;
		logic [1:0] bresp;
		logic arready;
		logic rvalid;
		word_t rdata;
		logic [1:0] rresp;
	} axil_rsp_t;

	typedef struct packed {
		logic o;
		logic s;
		logic c;
		logic z;
	} flags_t;

endpackage

`default_nettype wire

/* verilog/cpu_top.sv */
`default_nettype none

module cpu_top (
	input wire logic CLK,
	input wire logic rst_n,
	output cpu_pkg::axil_req_t axi_req,
	input cpu_pkg::axil_rsp_t axi_rsp,
	output logic halted
);
	import cpu_pkg::*;

	wire ctrl_t ctrl;
	wire instr_t instr;
	wire mem_req_t mem_req; // fields come from control and datapath
	wire mem_rsp_t mem_rsp;

	unit_control i_unit_control (
		.CLK(CLK),
		.rst_n(rst_n),
		.instr(instr),
		.mem_done(mem_rsp.done),
		.ctrl(ctrl),
		.mem_valid(mem_req.valid),
		.mem_write(mem_req.write),
		.halted(halted)
	);

	datapath i_datapath (
		.CLK(CLK),
		.rst_n(rst_n),
		.ctrl(ctrl),
		.mem_rdata(mem_rsp.rdata),
		.mem_done(mem_rsp.done),
		.instr(instr),
		.mem_addr(mem_req.addr),
		.mem_wdata(mem_req.wdata)
	);

	axil_master i_axil_master (
		.CLK(CLK),
		.rst_n(rst_n),
		.req(mem_req),
		.rsp(mem_rsp),
		.axi_req(axi_req),
		.axi_rsp(axi_rsp)
	);

endmodule

`default_nettype wire

/* verilog/datapath.sv */
`default_nettype none

module datapath (
	input wire logic CLK,
	input wire logic rst_n,
	input cpu_pkg::ctrl_t ctrl,
	input cpu_pkg::word_t mem_rdata,
	input wire logic mem_done,
	output cpu_pkg::instr_t instr,
	output cpu_pkg::word_t mem_addr,
	output cpu_pkg::word_t mem_wdata
);
	import cpu_pkg::*;

	word_t pc;
	word_t result_q; // execute address or result
	word_t mdr;
	word_t ra_data;
	word_t rb_data;
	word_t imm_ext;
	word_t op_b;
	word_t alu_result;
	word_t wb_data;
	word_t target;
	reg_idx_t rb_idx;
	logic taken;
	logic taken_q;
	logic is_jr;

	// non-alu types read rd on port b, used as store data
	assign rb_idx = (instr.r.itype == TYPE_ALU) ? instr.r.rb : instr.r.rd;
	assign imm_ext = {{16{instr.i.imm[15]}}, instr.i.imm};
	assign op_b = ctrl.sel_imm ? imm_ext : rb_data;

	assign is_jr = (instr.r.itype == TYPE_JUMP)
		&& ({instr.r.op[2], instr.r.op[3], instr.r.op[4]} != TF_LINK);
	assign target = is_jr ? ra_data : result_q;

	always_comb begin
		case (ctrl.wb_sel)
			WB_LINK: wb_data = pc; // pc already advanced past the jal
			WB_MEM: wb_data = mdr;
			default: wb_data = result_q;
		endcase
	end

	assign mem_addr = ctrl.w_ir ? pc : alu_result;
	assign mem_wdata = rb_data;

	always_ff @(posedge CLK) begin
		if (!rst_n) begin
			pc <= '0;
			instr <= '0;
			taken_q <= 1'b0;
		end else begin
			if (ctrl.w_ir && mem_done) begin
				instr <= mem_rdata;
				pc <= pc + 32'd4;
			end else if (ctrl.w_pc && taken_q) begin
				pc <= target;
			end
			if (ctrl.w_addr)
				taken_q <= taken;
		end
	end

	always_ff @(posedge CLK) begin
		if (ctrl.w_addr)
			result_q <= alu_result;
		if (mem_done)
			mdr <= mem_rdata; // load data, read in wb
	end

	alu i_alu (
		.CLK(CLK),
		.rst_n(rst_n),
		.op(ctrl.alu_op),
		.a(ra_data),
		.b(op_b),
		.w_rf(ctrl.w_rf),
		.tf(ctrl.tf),
		.result(alu_result),
		.taken(taken)
	);

	register_bank i_register_bank (
		.CLK(CLK),
		.rst_n(rst_n),
		.ra_idx(instr.r.ra),
		.rb_idx(rb_idx),
		.ra_data(ra_data),
		.rb_data(rb_data),
		.we(ctrl.w_rb),
		.wr_idx(instr.r.rd),
		.wr_data(wb_data)
	);

endmodule

`default_nettype wire

/* verilog/register_bank.sv */
`default_nettype none

module register_bank (
	input wire logic CLK,
	input wire logic rst_n,
	input cpu_pkg::reg_idx_t ra_idx,
	input cpu_pkg::reg_idx_t rb_idx,
	output cpu_pkg::word_t ra_data,
	output cpu_pkg::word_t rb_data,
	input wire logic we,
	input cpu_pkg::reg_idx_t wr_idx,
	input cpu_pkg::word_t wr_data
);
	import cpu_pkg::*;

	word_t regs [16];

	always_ff @(posedge CLK) begin
		if (!rst_n) begin
			for (int i = 0; i < 16; i++)
				regs[i] <= '0; // r0 starts as a zero base
		end else if (we) begin
			regs[wr_idx] <= wr_data;
		end
	end

	assign ra_data = regs[ra_idx];
	assign rb_data = regs[rb_idx];

endmodule

`default_nettype wire

/* verilog/unit_control.sv */
`default_nettype none

module unit_control (
	input wire logic CLK,
	input wire logic rst_n,
	input cpu_pkg::instr_t instr,
	input wire logic mem_done,
	output cpu_pkg::ctrl_t ctrl,
	output logic mem_valid,
	output logic mem_write,
	output logic halted
);
	import cpu_pkg::*;

	typedef enum logic [2:0] {
		S_IF,
		S_ID,
		S_EX,
		S_WB,
		S_HALT
	} state_t;

	state_t state;
	state_t state_nxt;
	ctrl_t dec;
	ctrl_t dec_q;
	logic is_mem;
	logic is_store;
	logic mem_q;
	logic store_q;
	tf_t op_tf;

	// flag mask by op class
	function automatic logic [2:0] flag_mask(input logic [4:0] op);
		if (op == OP_ONES)
			return FLG_NONE;
		if (op == OP_ZEROS)
			return FLG_Z;
		case (op[4:3])
			2'b00: return FLG_OSCZ;
			2'b01: return FLG_SCZ;
			default: return FLG_SZ;
		endcase
	endfunction

	assign op_tf = {instr.r.op[2], instr.r.op[3], instr.r.op[4]};

	always_comb begin
		dec = '0;
		dec.tf = TF_NEVER; // no pc load unless a branch says so
		dec.wb_sel = WB_ALU;
		dec.w_addr = 1'b1;
		is_mem = 1'b0;
		is_store = 1'b0;
		case (instr.r.itype)
			TYPE_ALU: begin
				dec.alu_op = instr.r.op;
				dec.w_rb = 1'b1;
				dec.w_rf = flag_mask(instr.r.op);
			end
			TYPE_CONST: begin
				dec.alu_op = instr.r.op;
				dec.sel_imm = 1'b1;
				dec.w_rb = 1'b1;
			end
			TYPE_MEM: begin
				dec.alu_op = OP_ADD; // ra + imm
				dec.sel_imm = 1'b1;
				dec.wb_sel = WB_MEM;
				dec.w_rb = ~instr.r.op[4];
				is_mem = 1'b1;
				is_store = instr.r.op[4];
			end
			TYPE_BRANCH: begin
				dec.alu_op = OP_PASS;
				dec.sel_imm = 1'b1;
				dec.tf = op_tf;
				dec.w_pc = 1'b1;
			end
			TYPE_JUMP: begin
				dec.alu_op = OP_PASS;
				dec.sel_imm = 1'b1;
				dec.w_pc = 1'b1;
				if (op_tf == TF_LINK) begin // jal
					dec.tf = TF_LINK;
					dec.w_rb = 1'b1;
					dec.wb_sel = WB_LINK;
				end else begin
					dec.tf = TF_ALWAYS; // jr, target taken from ra
				end
			end
			default: ;
		endcase
	end

	always_comb begin
		state_nxt = state;
		case (state)
			S_IF: if (mem_done) state_nxt = S_ID;
			S_ID: state_nxt = (instr.r.itype == TYPE_HALT) ? S_HALT : S_EX;
			S_EX: if (!mem_q || mem_done) state_nxt = S_WB;
			S_WB: state_nxt = S_IF;
			default: state_nxt = S_HALT; // left only by reset
		endcase
	end

	always_ff @(posedge CLK) begin
		if (!rst_n) begin
			state <= S_IF;
			dec_q <= '0;
			mem_q <= 1'b0;
			store_q <= 1'b0;
		end else begin
			state <= state_nxt;
			if (state == S_ID) begin
				dec_q <= dec;
				mem_q <= is_mem;
				store_q <= is_store;
			end
		end
	end

	// each field only in the state where it acts
	always_comb begin
		ctrl = '0;
		case (state)
			S_IF: ctrl.w_ir = 1'b1;
			S_EX: begin
				ctrl.alu_op = dec_q.alu_op;
				ctrl.tf = dec_q.tf;
				ctrl.sel_imm = dec_q.sel_imm;
				ctrl.w_addr = dec_q.w_addr;
			end
			S_WB: begin
				ctrl.w_pc = dec_q.w_pc;
				ctrl.w_rb = dec_q.w_rb;
				ctrl.w_rf = dec_q.w_rf;
				ctrl.wb_sel = dec_q.wb_sel;
			end
			default: ;
		endcase
	end

	assign mem_valid = (state == S_IF) || (state == S_EX && mem_q);
	assign mem_write = (state == S_EX) && store_q;
	assign halted = (state == S_HALT);

endmodule

`default_nettype wire
